/* source/cpuPkg.sv */
package cpuPkg;

    typedef logic [7:0] dataWord;             // Register, operand and memory byte
    typedef logic [7:0] memAddr;              // External memory address
    typedef logic [4:0] statusFlags;          // Sign, carry, zero, parity, overflow

    localparam int FlagSign     = 4;          // Result MSB, or A < B on compare
    localparam int FlagCarry    = 3;          // Carry out, borrow, or A > B on compare
    localparam int FlagZero     = 2;          // Result zero, or A == B on compare
    localparam int FlagParity   = 1;          // XOR of result bits
    localparam int FlagOverflow = 0;          // Signed overflow, or multiply high byte

    // Top bit of the code selects the logic unit
    typedef enum logic [3:0] {
        AluAdd  = 4'h0,
        AluSub  = 4'h1,
        AluMul  = 4'h2,
        AluDiv  = 4'h3,
        AluMod  = 4'h4,
        AluCmp  = 4'h5,
        AluAnd  = 4'h8,
        AluOr   = 4'h9,
        AluNot  = 4'hA,
        AluXor  = 4'hB,
        AluNand = 4'hC,
        AluNor  = 4'hD,
        AluXnor = 4'hE,
        AluPass = 4'hF
    } aluOp;

    localparam dataWord OpHalt = 8'h00;       // Stop and raise done
    localparam dataWord OpInc  = 8'h01;       // Unary, one operand byte
    localparam dataWord OpDec  = 8'h02;
    localparam dataWord OpNot  = 8'h03;
    localparam dataWord OpJump = 8'h04;       // Relative, one offset byte
    localparam dataWord OpAdd  = 8'h10;       // Binary, two operand bytes
    localparam dataWord OpSub  = 8'h20;
    localparam dataWord OpMul  = 8'h30;
    localparam dataWord OpDiv  = 8'h40;
    localparam dataWord OpMod  = 8'h50;
    localparam dataWord OpAnd  = 8'h60;
    localparam dataWord OpOr   = 8'h70;
    localparam dataWord OpXor  = 8'h80;
    localparam dataWord OpNand = 8'h90;
    localparam dataWord OpNor  = 8'hA0;
    localparam dataWord OpXnor = 8'hB0;
    localparam dataWord OpCmp  = 8'hC0;

endpackage

/* source/arithmeticUnit.sv */
module arithmeticUnit (
    input  cpuPkg::dataWord     operandA,
    input  cpuPkg::dataWord     operandB,
    input  cpuPkg::aluOp        op,
    output cpuPkg::dataWord     result,
    output cpuPkg::statusFlags  flags
);
    import cpuPkg::*;

    logic        invert;                    // Subtract as A + ~B + 1
    dataWord     addend;
    dataWord     sum;
    logic        carryOut;
    logic [15:0] product;
    dataWord     quotient;
    dataWord     remainder;

    // Ripple adder built from full adders
    always_comb begin
        logic carry;
        invert = (op == AluSub);
        addend = operandB ^ {8{invert}};
        carry  = invert;
        for (int i = 0; i < 8; i++) begin
            sum[i] = operandA[i] ^ addend[i] ^ carry;
            carry  = (operandA[i] & addend[i]) | (carry & (operandA[i] ^ addend[i]));
        end
        carryOut = carry;
    end

    // Shift-and-add multiplier
    always_comb begin
        product = '0;
        for (int i = 0; i < 8; i++) begin
            if (operandB[i]) product = product + ({8'd0, operandA} << i);
        end
    end

    // Successive subtraction, one quotient bit per step
    always_comb begin
        logic [8:0] partial;
        partial  = '0;
        quotient = '0;
        for (int i = 7; i >= 0; i--) begin
            partial = {partial[7:0], operandA[i]};
            if (partial >= {1'b0, operandB}) begin
                partial     = partial - {1'b0, operandB};
                quotient[i] = 1'b1;
            end
        end
        remainder = partial[7:0];
    end

    always_comb begin
        flags  = '0;
        result = '0;
        case (op)
            AluAdd: begin
                result              = sum;
                flags[FlagCarry]    = carryOut;
                flags[FlagOverflow] = (operandA[7] == operandB[7]) && (sum[7] != operandA[7]);
            end
            AluSub: begin
                result              = sum;
                flags[FlagCarry]    = ~carryOut;           // Borrow, A < B
                flags[FlagOverflow] = (operandA[7] != operandB[7]) && (sum[7] != operandA[7]);
            end
            AluMul: begin
                result              = product[7:0];        // Low byte kept
                flags[FlagOverflow] = (product[15:8] != 8'd0);
            end
            AluDiv:  result = (operandB == 8'd0) ? 8'hFF : quotient;
            AluMod:  result = (operandB == 8'd0) ? 8'hFF : remainder;
            default: result = '0;
        endcase
        flags[FlagSign]   = result[7];
        flags[FlagZero]   = (result == 8'd0);
        flags[FlagParity] = ^result;
        if ((op == AluDiv || op == AluMod) && operandB == 8'd0) begin
            flags = '1;                                     // Divide by zero
        end else if (op == AluCmp) begin
            flags             = '0;                         // Relation only
            flags[FlagZero]   = (operandA == operandB);
            flags[FlagSign]   = (operandA < operandB);
            flags[FlagCarry]  = (operandA > operandB);
        end
    end

endmodule

/* source/logicUnit.sv */
module logicUnit (
    input  cpuPkg::dataWord     operandA,
    input  cpuPkg::dataWord     operandB,
    input  cpuPkg::aluOp        op,
    output cpuPkg::dataWord     result,
    output cpuPkg::statusFlags  flags
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            AluAnd:  result = operandA & operandB;
            AluOr:   result = operandA | operandB;
            AluNot:  result = ~operandA;            // Unary, B ignored
            AluXor:  result = operandA ^ operandB;
            AluNand: result = ~(operandA & operandB);
            AluNor:  result = ~(operandA | operandB);
            AluXnor: result = ~(operandA ^ operandB);
            default: result = operandA;             // Pass A through
        endcase
    end

    // No carry or overflow from bitwise ops
    always_comb begin
        flags               = '0;
        flags[FlagSign]     = result[7];
        flags[FlagZero]     = (result == 8'd0);
        flags[FlagParity]   = ^result;
    end

endmodule

/* source/controlSequencer.sv */
module controlSequencer (
    input  logic             clock,
    input  logic             reset,
    input  cpuPkg::dataWord  ir,             // Opcode of the current instruction
    output logic             pcInc,
    output logic             pcJump,
    output logic             irLoad,
    output logic             aLoad,
    output logic             bLoad,
    output logic             bLoadOne,
    output logic             resultLoad,     // Loads C and the status register
    output logic             store,          // Memory write and pointer bump
    output cpuPkg::aluOp     op,
    output logic             done
);
    import cpuPkg::*;

    typedef enum logic [3:0] {
        Fetch, Decode, LoadA, LoadB, LoadOne, Execute, Store, Jump, Halted
    } seqState;

    seqState state, nextState;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= Fetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = Fetch;                          // Fall back to fetch
        case (state)
            Fetch:   nextState = Decode;
            Decode: begin
                case (ir)
                    OpHalt:  nextState = Halted;
                    OpJump:  nextState = LoadB;     // Offset goes to B
                    OpInc, OpDec, OpNot,
                    OpAdd, OpSub, OpMul, OpDiv, OpMod,
                    OpAnd, OpOr, OpXor, OpNand, OpNor, OpXnor,
                    OpCmp:   nextState = LoadA;
                    default: nextState = Fetch;     // Unknown opcode skipped
                endcase
            end
            LoadA: begin
                if (ir == OpNot) begin
                    nextState = Execute;            // Single operand
                end else if (ir == OpInc || ir == OpDec) begin
                    nextState = LoadOne;
                end else begin
                    nextState = LoadB;
                end
            end
            LoadB:   nextState = (ir == OpJump) ? Jump : Execute;
            LoadOne: nextState = Execute;
            Execute: nextState = Store;
            Store:   nextState = Fetch;
            Jump:    nextState = Fetch;
            Halted:  nextState = Halted;            // Only reset leaves
            default: nextState = Fetch;
        endcase
    end

    always_comb begin
        pcInc      = 1'b0;
        pcJump     = 1'b0;
        irLoad     = 1'b0;
        aLoad      = 1'b0;
        bLoad      = 1'b0;
        bLoadOne   = 1'b0;
        resultLoad = 1'b0;
        store      = 1'b0;
        case (state)
            Fetch: begin
                irLoad = 1'b1;
                pcInc  = 1'b1;
            end
            LoadA: begin
                aLoad = 1'b1;
                pcInc = 1'b1;
            end
            LoadB: begin
                bLoad = 1'b1;
                pcInc = 1'b1;
            end
            LoadOne: bLoadOne   = 1'b1;
            Execute: resultLoad = 1'b1;
            Store:   store      = 1'b1;
            Jump:    pcJump     = 1'b1;
            default: ;                              // Decode and Halted drive nothing
        endcase
    end

    // Opcode to ALU operation with inc and dec reusing add and sub on B = 1
    always_comb begin
        case (ir)
            OpInc, OpAdd: op = AluAdd;
            OpDec, OpSub: op = AluSub;
            OpMul:        op = AluMul;
            OpDiv:        op = AluDiv;
            OpMod:        op = AluMod;
            OpCmp:        op = AluCmp;
            OpNot:        op = AluNot;
            OpAnd:        op = AluAnd;
            OpOr:         op = AluOr;
            OpXor:        op = AluXor;
            OpNand:       op = AluNand;
            OpNor:        op = AluNor;
            OpXnor:       op = AluXnor;
            default:      op = AluPass;
        endcase
    end

    assign done = (state == Halted);

endmodule

/* source/dataPath.sv */
module dataPath #(
    parameter cpuPkg::memAddr ResultBase = 8'd128
) (
    input  logic                clock,
    input  logic                reset,
    input  cpuPkg::dataWord     readData,
    input  logic                pcInc,
    input  logic                pcJump,
    input  logic                irLoad,
    input  logic                aLoad,
    input  logic                bLoad,
    input  logic                bLoadOne,
    input  logic                resultLoad,
    input  logic                store,
    input  cpuPkg::dataWord     arithResult,
    input  cpuPkg::statusFlags  arithFlags,
    input  cpuPkg::dataWord     logicResult,
    input  cpuPkg::statusFlags  logicFlags,
    input  cpuPkg::aluOp        op,
    output cpuPkg::dataWord     ir,
    output cpuPkg::dataWord     operandA,
    output cpuPkg::dataWord     operandB,
    output cpuPkg::memAddr      address,
    output cpuPkg::dataWord     writeData,
    output cpuPkg::statusFlags  flags
);
    import cpuPkg::*;

    memAddr     pc;
    memAddr     answerPtr;                  // Next free byte of the answer area
    dataWord    regC;                       // Result waiting for store
    statusFlags status;
    dataWord    aluResult;
    statusFlags aluFlags;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (pcJump) begin
            pc <= pc + operandB;            // PC already past the offset byte
        end else if (pcInc) begin
            pc <= pc + 8'd1;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ir       <= '0;
            operandA <= '0;
            operandB <= '0;
        end else begin
            if (irLoad) ir <= readData;
            if (aLoad) operandA <= readData;
            if (bLoad) begin
                operandB <= readData;
            end else if (bLoadOne) begin
                operandB <= 8'd1;           // Step for inc and dec
            end
        end
    end

    // Top bit of op picks the logic unit
    assign aluResult = op[3] ? logicResult : arithResult;
    assign aluFlags  = op[3] ? logicFlags : arithFlags;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            regC      <= '0;
            status    <= '0;
            answerPtr <= '0;
        end else begin
            if (resultLoad) begin
                regC   <= aluResult;
                status <= aluFlags;
            end
            if (store) answerPtr <= answerPtr + 8'd1;
        end
    end

    assign address   = store ? memAddr'(ResultBase + answerPtr) : pc;  // Answer slot only in Store
    assign writeData = regC;
    assign flags     = status;

endmodule

/* source/processorCore.sv */
module processorCore #(
    parameter cpuPkg::memAddr ResultBase = 8'd128    // First byte of the answer area
) (
    input  logic                 clock,
    input  logic                 reset,
    input  cpuPkg::dataWord      readData,           // Combinational memory read
    output cpuPkg::memAddr       address,
    output cpuPkg::dataWord      writeData,
    output logic                 writeEnable,        // One-cycle store strobe
    output logic                 done,               // Level, high once halted
    output cpuPkg::statusFlags   flags
);
    import cpuPkg::*;

    logic       pcInc, pcJump, irLoad;               // Sequencer strobes
    logic       aLoad, bLoad, bLoadOne, resultLoad;
    aluOp       op;
    dataWord    ir;
    dataWord    operandA, operandB;
    dataWord    arithResult, logicResult;
    statusFlags arithFlags, logicFlags;

    // Store strobe doubles as the memory write enable
    controlSequencer sequencer_inst (
        .clock(clock), .reset(reset), .ir(ir),
        .pcInc(pcInc), .pcJump(pcJump), .irLoad(irLoad),
        .aLoad(aLoad), .bLoad(bLoad), .bLoadOne(bLoadOne),
        .resultLoad(resultLoad), .store(writeEnable), .op(op), .done(done)
    );

    dataPath #(
        .ResultBase(ResultBase)
    ) dataPath_inst (
        .clock(clock), .reset(reset), .readData(readData),
        .pcInc(pcInc), .pcJump(pcJump), .irLoad(irLoad),
        .aLoad(aLoad), .bLoad(bLoad), .bLoadOne(bLoadOne),
        .resultLoad(resultLoad), .store(writeEnable),
        .arithResult(arithResult), .arithFlags(arithFlags),
        .logicResult(logicResult), .logicFlags(logicFlags), .op(op),
        .ir(ir), .operandA(operandA), .operandB(operandB),
        .address(address), .writeData(writeData), .flags(flags)
    );

    arithmeticUnit arith_inst (
        .operandA(operandA), .operandB(operandB), .op(op),
        .result(arithResult), .flags(arithFlags)
    );

    logicUnit logic_inst (
        .operandA(operandA), .operandB(operandB), .op(op),
        .result(logicResult), .flags(logicFlags)
    );

endmodule

/* sim/clockGen.sv */
module clockGen (
    output logic clock,
    output logic reset                    // Active low
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HalfPeriod = 4;        // 8 ns period
    localparam int ResetCycles = 8;

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        repeat (ResetCycles) @(posedge clock);
        reset <= 1'b1;                    // Release on a rising edge
    end

    always #HalfPeriod clock = ~clock;

endmodule

/* sim/processorTb.sv */
module processorTb #(
    parameter int ResultBase = 128,       // First byte of the answer area
    parameter int ProgramTop = 127        // Program stays below this address
);
    timeunit 1ns;
    timeprecision 100ps;
    import cpuPkg::*;

    localparam int WaitLimit = 300;       // Cycles allowed for any single wait

    logic       clock, reset;
    dataWord    readData, writeData;
    memAddr     address;
    logic       writeEnable, done;
    statusFlags flags;
    logic [7:0] mem [256];
    logic [20:0] expWrites [$];           // {address, data, flags}
    integer     seed;

    clockGen clockGen_inst (.clock(clock), .reset(reset));

    processorCore #(
        .ResultBase(8'(ResultBase))
    ) processorCore_inst (
        .clock(clock), .reset(reset), .readData(readData),
        .address(address), .writeData(writeData), .writeEnable(writeEnable),
        .done(done), .flags(flags)
    );

    assign readData = mem[address];       // Combinational read

    always @(posedge clock) begin
        if (writeEnable === 1'b1) mem[address] <= writeData;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            failRun($sformatf("Error %s expected %h got %h", name, expected, actual));
        end
    endtask

    function automatic logic [7:0] randomByte();
        return 8'($random(seed));
    endfunction

    function automatic int randomBelow(input int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    // Expected {result, flags} straight from the instruction rules
    function automatic logic [12:0] modelAlu(input logic [7:0] opc, input logic [7:0] a,
                                             input logic [7:0] b);
        logic [15:0] wide;
        logic [7:0]  res;
        logic [4:0]  flg;
        logic        plainFlags;
        flg = '0;
        res = '0;
        plainFlags = 1'b1;
        case (opc)
            8'h01, 8'h10: begin
                wide = {8'd0, a} + {8'd0, b};
                res = wide[7:0];
                flg[FlagCarry] = wide[8];
                flg[FlagOverflow] = (a[7] == b[7]) && (res[7] != a[7]);
            end
            8'h02, 8'h20: begin
                res = a - b;
                flg[FlagCarry] = (a < b);     // Borrow
                flg[FlagOverflow] = (a[7] != b[7]) && (res[7] != a[7]);
            end
            8'h30: begin
                wide = {8'd0, a} * {8'd0, b};
                res = wide[7:0];
                flg[FlagOverflow] = (wide[15:8] != 8'd0);
            end
            8'h40, 8'h50: begin
                if (b == 8'd0) begin
                    res = 8'hFF;
                    flg = 5'h1F;              // Divide by zero sets everything
                    plainFlags = 1'b0;
                end else begin
                    res = (opc == 8'h40) ? a / b : a % b;
                end
            end
            8'hC0: begin
                plainFlags = 1'b0;
                flg[FlagZero] = (a == b);
                flg[FlagSign] = (a < b);
                flg[FlagCarry] = (a > b);
            end
            8'h03: res = ~a;
            8'h60: res = a & b;
            8'h70: res = a | b;
            8'h80: res = a ^ b;
            8'h90: res = ~(a & b);
            8'hA0: res = ~(a | b);
            default: res = ~(a ^ b);          // XNOR
        endcase
        if (plainFlags) begin
            flg[FlagSign] = res[7];
            flg[FlagZero] = (res == 8'd0);
            flg[FlagParity] = ^res;
        end
        return {res, flg};
    endfunction

    task automatic buildProgram();
        logic [7:0] binaryOps [12];
        int pc;
        int kind;
        int offset;
        binaryOps = '{8'h10, 8'h20, 8'h30, 8'h40, 8'h50, 8'h60,
                      8'h70, 8'h80, 8'h90, 8'hA0, 8'hB0, 8'hC0};
        for (int i = 0; i < 256; i++) mem[i] = 8'(i) ^ 8'h5A;   // Background pattern
        pc = 0;
        while (pc <= ProgramTop - 8) begin
            kind = randomBelow(10);
            if (kind < 6) begin
                mem[pc] = binaryOps[randomBelow(12)];
                mem[pc + 1] = randomByte();
                mem[pc + 2] = (randomBelow(8) == 0) ? 8'd0 : randomByte();  // Some zero divisors
                pc += 3;
            end else if (kind < 8) begin
                mem[pc] = 8'(1 + randomBelow(3));           // Inc, dec or NOT
                mem[pc + 1] = randomByte();
                pc += 2;
            end else if (kind == 8) begin
                offset = randomBelow(6);
                mem[pc] = 8'h04;
                mem[pc + 1] = 8'(offset);
                for (int i = 0; i < offset; i++) mem[pc + 2 + i] = randomByte();  // Skipped filler
                pc += 2 + offset;
            end else begin
                mem[pc] = 8'(5 + randomBelow(11));          // Unknown opcode 05..0F
                pc += 1;
            end
        end
        mem[pc] = 8'h00;                                    // Final halt
    endtask

    // Walk the program as the core should and queue every write
    task automatic runModel();
        logic [7:0]  pc;
        logic [7:0]  ptr;
        logic [7:0]  opc, a, b;
        logic [12:0] outcome;
        logic        halted;
        pc = '0;
        ptr = '0;
        halted = 1'b0;
        for (int steps = 0; steps < 256 && !halted; steps++) begin
            opc = mem[pc];
            pc = pc + 8'd1;
            if (opc == 8'h00) begin
                halted = 1'b1;
            end else if (opc == 8'h04) begin
                pc = pc + 8'd1 + mem[pc];                   // From the byte after the offset
            end else if (opc >= 8'h01 && opc <= 8'h03 ||
                         opc[3:0] == 4'h0 && opc >= 8'h10 && opc <= 8'hC0) begin
                a = mem[pc];
                pc = pc + 8'd1;
                b = 8'd1;                                   // Step for inc and dec
                if (opc >= 8'h10) begin
                    b = mem[pc];
                    pc = pc + 8'd1;
                end
                outcome = modelAlu(opc, a, b);
                expWrites.push_back({8'(ResultBase) + ptr, outcome});
                ptr = ptr + 8'd1;
            end
        end
        if (!halted) failRun("Reference model never reached the halt opcode");
    endtask

    task automatic waitForWrite(input int remaining);
        for (int cycles = 0; cycles < WaitLimit; cycles++) begin
            @(negedge clock);
            if (writeEnable === 1'b1) return;
            if (done === 1'b1) begin
                failRun($sformatf("Core halted with %0d writes still expected", remaining));
            end
        end
        failRun("Timed out waiting for a memory write");
    endtask

    task automatic waitForDone();
        for (int cycles = 0; cycles < WaitLimit; cycles++) begin
            @(negedge clock);
            if (writeEnable === 1'b1) failRun("Core wrote more results than expected");
            if (done === 1'b1) return;
        end
        failRun("Timed out waiting for done after the last write");
    endtask

    initial begin
        logic [20:0] expected;
        logic        released;
        seed = 32'h1188;
        buildProgram();
        runModel();
        released = 1'b0;
        @(posedge clock);                               // Reset has been applied by now
        // Outputs idle during reset and in the first cycle after it
        for (int cycles = 0; cycles < 40 && !released; cycles++) begin
            @(negedge clock);
            checkValue("writeEnable", 8'd0, 8'(writeEnable));
            checkValue("done", 8'd0, 8'(done));
            checkValue("address", 8'd0, address);
            released = (reset === 1'b1);
        end
        if (!released) failRun("Reset was never released");
        while (expWrites.size() > 0) begin
            expected = expWrites.pop_front();
            waitForWrite(expWrites.size() + 1);
            checkValue("address", expected[20:13], address);
            checkValue("writeData", expected[12:5], writeData);
            checkValue("flags", 8'(expected[4:0]), 8'(flags));
        end
        waitForDone();
        repeat (20) begin
            @(negedge clock);
            checkValue("writeEnable", 8'd0, 8'(writeEnable));
            checkValue("done", 8'd1, 8'(done));         // Level holds until reset
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* list.f */
source/cpuPkg.sv
source/arithmeticUnit.sv
source/logicUnit.sv
source/controlSequencer.sv
source/dataPath.sv
source/processorCore.sv
sim/clockGen.sv
sim/processorTb.sv
